//--- source/axi_master_cfg.svh
`ifndef AXI_MASTER_CFG_SVH
`define AXI_MASTER_CFG_SVH

// AXI bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_ID_W   4
`define AXI_LEN_W  4

// Local memory, 4 KB of bytes
`define MEM_BYTES  4096
`define MEM_ADDR_W 12

`endif

//--- source/axi_pkg.sv
`include "axi_master_cfg.svh"

package axi_pkg;

    // Burst kinds as carried on ARBURST, 2'b11 is reserved
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    // log2 of bytes per beat
    typedef logic [2:0] axi_size_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    typedef logic [`AXI_ID_W-1:0]   axi_id_t;
    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [`AXI_LEN_W-1:0]  axi_len_t;

endpackage

//--- source/mem_pkg.sv
`include "axi_master_cfg.svh"

package mem_pkg;

    // One storage cell of the local memory
    typedef logic [7:0] mem_byte_t;

    // Byte index into the local memory
    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

endpackage

//--- source/burst_addr_gen.sv
`timescale 1ns/1ps

module burst_addr_gen (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_i,
    input  mem_pkg::mem_addr_t  start_addr_i,
    input  axi_pkg::axi_len_t   len_i,
    input  axi_pkg::axi_size_t  size_i,
    input  axi_pkg::axi_burst_e burst_i,
    input  logic                step_i,
    output mem_pkg::mem_addr_t  addr_o
);
    import axi_pkg::*;
    import mem_pkg::*;

    mem_addr_t  addr_q;
    mem_addr_t  beat_bytes_q;
    mem_addr_t  wrap_bytes_q;
    axi_burst_e burst_q;
    mem_addr_t  addr_inc;

    assign addr_inc = addr_q + beat_bytes_q;
    assign addr_o   = addr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q       <= '0;
            beat_bytes_q <= '0;
            wrap_bytes_q <= '0;
            burst_q      <= FIXED;
        end else if (load_i) begin
            addr_q       <= start_addr_i;
            beat_bytes_q <= mem_addr_t'(1) << size_i;
            // Window size is beats times beat bytes, a power of two for legal WRAP lengths
            wrap_bytes_q <= (mem_addr_t'(len_i) + 1'b1) << size_i;
            burst_q      <= burst_i;
        end else if (step_i) begin
            case (burst_q)
                INCR: begin
                    addr_q <= addr_inc;
                end
                WRAP: begin
                    // Crossing the window end folds back to its aligned base
                    if ((addr_inc & (wrap_bytes_q - 1'b1)) == '0) begin
                        addr_q <= addr_inc - wrap_bytes_q;
                    end else begin
                        addr_q <= addr_inc;
                    end
                end
                default: begin
                    addr_q <= addr_q;
                end
            endcase
        end
    end

endmodule

//--- source/rd_addr_channel.sv
`timescale 1ns/1ps

module rd_addr_channel (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid_i,
    input  axi_pkg::axi_id_t    req_id_i,
    input  axi_pkg::axi_addr_t  req_addr_i,
    input  axi_pkg::axi_len_t   req_len_i,
    input  axi_pkg::axi_size_t  req_size_i,
    input  axi_pkg::axi_burst_e req_burst_i,
    input  logic                arready_i,
    input  logic                burst_end_i,
    output logic                req_ready_o,
    output axi_pkg::axi_id_t    arid_o,
    output axi_pkg::axi_addr_t  araddr_o,
    output axi_pkg::axi_len_t   arlen_o,
    output axi_pkg::axi_size_t  arsize_o,
    output axi_pkg::axi_burst_e arburst_o,
    output logic                arvalid_o,
    output logic                burst_active_o
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } state_e;

    state_e state_q;
    state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_valid_i) begin
                    state_d = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (arready_i) begin
                    state_d = ST_DATA;
                end
            end
            ST_DATA: begin
                if (burst_end_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // AR fields stay put from the request until the next one is taken
    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            arid_o    <= req_id_i;
            araddr_o  <= req_addr_i;
            arlen_o   <= req_len_i;
            arsize_o  <= req_size_i;
            arburst_o <= req_burst_i;
        end
    end

    assign req_ready_o    = (state_q == ST_IDLE);
    assign arvalid_o      = (state_q == ST_ADDR);
    assign burst_active_o = (state_q == ST_DATA);

endmodule

//--- source/rd_data_channel.sv
`timescale 1ns/1ps
`include "axi_master_cfg.svh"

module rd_data_channel (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   burst_active_i,
    input  logic                   ar_start_i,
    input  axi_pkg::axi_addr_t     araddr_i,
    input  axi_pkg::axi_len_t      arlen_i,
    input  axi_pkg::axi_size_t     arsize_i,
    input  axi_pkg::axi_burst_e    arburst_i,
    input  logic [`AXI_DATA_W-1:0] rdata_i,
    input  axi_pkg::axi_resp_t     rresp_i,
    input  logic                   rlast_i,
    input  logic                   rvalid_i,
    output logic                   rready_o,
    output logic                   burst_end_o,
    output logic                   done_o,
    output axi_pkg::axi_resp_t     resp_o,
    output logic                   mem_we_o,
    output mem_pkg::mem_addr_t     mem_waddr_o,
    output logic [`AXI_DATA_W-1:0] mem_wdata_o,
    output axi_pkg::axi_size_t     mem_wsize_o
);
    import axi_pkg::*;

    logic      beat;
    axi_resp_t worst_q;
    axi_resp_t worst_d;

    // Ready for the whole data phase, so beats are never dropped mid-burst
    assign rready_o    = burst_active_i;
    assign beat        = rvalid_i && rready_o;
    assign burst_end_o = beat && rlast_i;

    assign mem_we_o    = beat;
    assign mem_wdata_o = rdata_i;
    assign mem_wsize_o = arsize_i;

    burst_addr_gen u_addr_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_i       (ar_start_i),
        .start_addr_i (araddr_i[`MEM_ADDR_W-1:0]),
        .len_i        (arlen_i),
        .size_i       (arsize_i),
        .burst_i      (arburst_i),
        .step_i       (beat),
        .addr_o       (mem_waddr_o)
    );

    // DECERR beats SLVERR, SLVERR beats OKAY
    always_comb begin
        worst_d = worst_q;
        if (rresp_i == DECERR) begin
            worst_d = DECERR;
        end else if (rresp_i == SLVERR && worst_q != DECERR) begin
            worst_d = SLVERR;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            worst_q <= OKAY;
            done_o  <= 1'b0;
            resp_o  <= OKAY;
        end else begin
            done_o <= burst_end_o;
            if (ar_start_i) begin
                worst_q <= OKAY;
            end else if (beat) begin
                worst_q <= worst_d;
            end
            // Last beat's own response is folded in here
            if (burst_end_o) begin
                resp_o <= worst_d;
            end
        end
    end

endmodule

//--- source/local_mem.sv
`timescale 1ns/1ps
`include "axi_master_cfg.svh"

module local_mem (
    input  logic                   clk,
    input  logic                   we_i,
    input  mem_pkg::mem_addr_t     waddr_i,
    input  logic [`AXI_DATA_W-1:0] wdata_i,
    input  axi_pkg::axi_size_t     wsize_i,
    input  mem_pkg::mem_addr_t     raddr_i,
    output mem_pkg::mem_byte_t     rdata_o
);
    import mem_pkg::*;

    localparam int LANES = `AXI_DATA_W / 8;

    mem_byte_t mem_q [`MEM_BYTES];

    always_ff @(posedge clk) begin
        if (we_i) begin
            // Low bytes go to consecutive cells, wrapping at the top of memory
            for (int i = 0; i < LANES; i++) begin
                if (i < (1 << wsize_i)) begin
                    mem_q[waddr_i + mem_addr_t'(i)] <= wdata_i[8*i +: 8];
                end
            end
        end
        rdata_o <= mem_q[raddr_i];
    end

endmodule

//--- source/axi_rd_master.sv
`timescale 1ns/1ps
`include "axi_master_cfg.svh"

module axi_rd_master (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  axi_pkg::axi_id_t       req_id_i,
    input  axi_pkg::axi_addr_t     req_addr_i,
    input  axi_pkg::axi_len_t      req_len_i,
    input  axi_pkg::axi_size_t     req_size_i,
    input  axi_pkg::axi_burst_e    req_burst_i,
    output axi_pkg::axi_id_t       arid_o,
    output axi_pkg::axi_addr_t     araddr_o,
    output axi_pkg::axi_len_t      arlen_o,
    output axi_pkg::axi_size_t     arsize_o,
    output axi_pkg::axi_burst_e    arburst_o,
    output logic                   arvalid_o,
    input  logic                   arready_i,
    input  axi_pkg::axi_id_t       rid_i,
    input  logic [`AXI_DATA_W-1:0] rdata_i,
    input  axi_pkg::axi_resp_t     rresp_i,
    input  logic                   rlast_i,
    input  logic                   rvalid_i,
    output logic                   rready_o,
    output logic                   done_o,
    output axi_pkg::axi_resp_t     resp_o,
    input  mem_pkg::mem_addr_t     mem_raddr_i,
    output mem_pkg::mem_byte_t     mem_rdata_o
);
    import axi_pkg::*;
    import mem_pkg::*;

    logic                   burst_active;
    logic                   burst_end;
    logic                   ar_start;
    logic                   mem_we;
    mem_addr_t              mem_waddr;
    logic [`AXI_DATA_W-1:0] mem_wdata;
    axi_size_t              mem_wsize;

    assign ar_start = arvalid_o && arready_i;

    rd_addr_channel u_ar (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid_i    (req_valid_i),
        .req_id_i       (req_id_i),
        .req_addr_i     (req_addr_i),
        .req_len_i      (req_len_i),
        .req_size_i     (req_size_i),
        .req_burst_i    (req_burst_i),
        .arready_i      (arready_i),
        .burst_end_i    (burst_end),
        .req_ready_o    (req_ready_o),
        .arid_o         (arid_o),
        .araddr_o       (araddr_o),
        .arlen_o        (arlen_o),
        .arsize_o       (arsize_o),
        .arburst_o      (arburst_o),
        .arvalid_o      (arvalid_o),
        .burst_active_o (burst_active)
    );

    // Burst parameters come straight from the held AR fields
    rd_data_channel u_r (
        .clk            (clk),
        .rst_n          (rst_n),
        .burst_active_i (burst_active),
        .ar_start_i     (ar_start),
        .araddr_i       (araddr_o),
        .arlen_i        (arlen_o),
        .arsize_i       (arsize_o),
        .arburst_i      (arburst_o),
        .rdata_i        (rdata_i),
        .rresp_i        (rresp_i),
        .rlast_i        (rlast_i),
        .rvalid_i       (rvalid_i),
        .rready_o       (rready_o),
        .burst_end_o    (burst_end),
        .done_o         (done_o),
        .resp_o         (resp_o),
        .mem_we_o       (mem_we),
        .mem_waddr_o    (mem_waddr),
        .mem_wdata_o    (mem_wdata),
        .mem_wsize_o    (mem_wsize)
    );

    local_mem u_mem (
        .clk     (clk),
        .we_i    (mem_we),
        .waddr_i (mem_waddr),
        .wdata_i (mem_wdata),
        .wsize_i (mem_wsize),
        .raddr_i (mem_raddr_i),
        .rdata_o (mem_rdata_o)
    );

endmodule

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 20.0,
    parameter int  RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

    // Reset released on a rising edge after a few cycles
    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- sim/axi_rd_master_checker.sv
`timescale 1ns/1ps

module axi_rd_master_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                req_ready_i,
    input axi_pkg::axi_id_t    arid_i,
    input axi_pkg::axi_addr_t  araddr_i,
    input axi_pkg::axi_len_t   arlen_i,
    input axi_pkg::axi_size_t  arsize_i,
    input axi_pkg::axi_burst_e arburst_i,
    input logic                arvalid_i,
    input logic                arready_i,
    input logic                rready_i,
    input logic                done_i
);
    int fail_count = 0;

    // AR request must hold while the slave stalls
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i && !arready_i |=>
            arvalid_i && $stable({arid_i, araddr_i, arlen_i, arsize_i, arburst_i}))
    else begin
        fail_count++;
        $error("AR channel changed before arready");
    end

    no_ready_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(rready_i && req_ready_i))
    else begin
        fail_count++;
        $error("rready high while a new request can be taken");
    end

    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |=> !done_i)
    else begin
        fail_count++;
        $error("done held for more than one cycle");
    end

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !arvalid_i && !rready_i)
    else begin
        fail_count++;
        $error("arvalid or rready high right after reset");
    end

endmodule

bind axi_rd_master axi_rd_master_checker u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_ready_i (req_ready_o),
    .arid_i      (arid_o),
    .araddr_i    (araddr_o),
    .arlen_i     (arlen_o),
    .arsize_i    (arsize_o),
    .arburst_i   (arburst_o),
    .arvalid_i   (arvalid_o),
    .arready_i   (arready_i),
    .rready_i    (rready_o),
    .done_i      (done_o)
);

//--- sim/tb_axi_rd_master.sv
`timescale 1ns/1ps
`include "axi_master_cfg.svh"

module tb_axi_rd_master;
    import axi_pkg::*;
    import mem_pkg::*;

    localparam int TESTS         = 5;
    localparam int MAX_BEATS     = 16;
    localparam int MAX_GAP       = 8;
    localparam int TEST_OVERHEAD = 40;
    localparam int CYCLE_LIMIT   =
        ((TESTS * (MAX_BEATS * MAX_GAP + TEST_OVERHEAD) + 999) / 1000) * 1000;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid_i;
    logic                   req_ready_o;
    axi_id_t                req_id_i;
    axi_addr_t              req_addr_i;
    axi_len_t               req_len_i;
    axi_size_t              req_size_i;
    axi_burst_e             req_burst_i;
    axi_id_t                arid_o;
    axi_addr_t              araddr_o;
    axi_len_t               arlen_o;
    axi_size_t              arsize_o;
    axi_burst_e             arburst_o;
    logic                   arvalid_o;
    logic                   arready_i;
    axi_id_t                rid_i;
    logic [`AXI_DATA_W-1:0] rdata_i;
    axi_resp_t              rresp_i;
    logic                   rlast_i;
    logic                   rvalid_i;
    logic                   rready_o;
    logic                   done_o;
    axi_resp_t              resp_o;
    mem_addr_t              mem_raddr_i;
    mem_byte_t              mem_rdata_o;

    int          errors       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          done_pulses  = 0;
    int          cycles       = 0;
    logic [15:0] lfsr_q       = 16'd36;
    logic [7:0]  exp_bytes [int];

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    axi_rd_master dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_id_i    (req_id_i),
        .req_addr_i  (req_addr_i),
        .req_len_i   (req_len_i),
        .req_size_i  (req_size_i),
        .req_burst_i (req_burst_i),
        .arid_o      (arid_o),
        .araddr_o    (araddr_o),
        .arlen_o     (arlen_o),
        .arsize_o    (arsize_o),
        .arburst_o   (arburst_o),
        .arvalid_o   (arvalid_o),
        .arready_i   (arready_i),
        .rid_i       (rid_i),
        .rdata_i     (rdata_i),
        .rresp_i     (rresp_i),
        .rlast_i     (rlast_i),
        .rvalid_i    (rvalid_i),
        .rready_o    (rready_o),
        .done_o      (done_o),
        .resp_o      (resp_o),
        .mem_raddr_i (mem_raddr_i),
        .mem_rdata_o (mem_rdata_o)
    );

    always @(posedge clk) begin
        if (done_o) begin
            done_pulses <= done_pulses + 1;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    // Id in the top byte, beat number in the low byte
    function automatic logic [31:0] beat_data(input axi_id_t id, input int n);
        return {4'h0, id, 8'(n + 32), 8'(n + 16), 8'(n)};
    endfunction

    // Beat address as the AXI burst rules define it
    function automatic int beat_addr(input int start, input int n, input int size,
                                     input int len, input axi_burst_e burst);
        int bytes;
        int total;
        int base;
        bytes = 1 << size;
        total = bytes * (len + 1);
        case (burst)
            FIXED: return start % `MEM_BYTES;
            WRAP: begin
                base = (start / total) * total;
                return (base + ((start - base + n * bytes) % total)) % `MEM_BYTES;
            end
            default: return (start + n * bytes) % `MEM_BYTES;
        endcase
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s %s expected 0x%0h actual 0x%0h", test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("%s: pass", name);
        end else begin
            $display("%s: fail", name);
            tests_failed++;
        end
    endtask

    task automatic verify_memory(input string name);
        foreach (exp_bytes[a]) begin
            @(posedge clk);
            mem_raddr_i <= mem_addr_t'(a);
            @(posedge clk);
            @(negedge clk);
            check_value(name, $sformatf("byte 0x%03h", a), exp_bytes[a], mem_rdata_o);
        end
    endtask

    // Issues one request and plays the slave for its AR and R phases
    task automatic drive_burst(input string name, input axi_id_t id, input int addr,
                               input int len, input int size, input axi_burst_e burst,
                               input int err_beat, input bit random_timing);
        int          ar_wait;
        int          gap;
        int          beat;
        int          a;
        int          pulses_before;
        bit          holding;
        bit          ar_done;
        bit          seen;
        logic [31:0] data;
        axi_resp_t   exp_resp;

        exp_bytes.delete();
        pulses_before = done_pulses;
        exp_resp = (err_beat >= 0 && err_beat <= len) ? SLVERR : OKAY;
        for (int n = 0; n <= len; n++) begin
            data = beat_data(id, n);
            a = beat_addr(addr, n, size, len, burst);
            for (int i = 0; i < (1 << size); i++) begin
                exp_bytes[(a + i) % `MEM_BYTES] = data[8*i +: 8];
            end
        end

        @(posedge clk);
        req_valid_i <= 1'b1;
        req_id_i    <= id;
        req_addr_i  <= axi_addr_t'(addr);
        req_len_i   <= axi_len_t'(len);
        req_size_i  <= axi_size_t'(size);
        req_burst_i <= burst;
        do begin
            @(negedge clk);
        end while (!req_ready_o);
        @(posedge clk);
        req_valid_i <= 1'b0;

        ar_wait = random_timing ? rand_bits(3) : 0;
        ar_done = 1'b0;
        while (!ar_done) begin
            @(posedge clk);
            arready_i <= (ar_wait == 0);
            if (ar_wait > 0) begin
                ar_wait--;
            end
            @(negedge clk);
            ar_done = arvalid_o && arready_i;
        end

        // AR carries the request as it was taken
        check_value(name, "arid", id, arid_o);
        check_value(name, "araddr", addr, araddr_o);
        check_value(name, "arlen", len, arlen_o);
        check_value(name, "arsize", size, arsize_o);
        check_value(name, "arburst", burst, arburst_o);

        beat = 0;
        holding = 1'b0;
        gap = random_timing ? rand_bits(3) : 0;
        while (beat <= len) begin
            @(posedge clk);
            arready_i <= 1'b0;
            if (!holding) begin
                if (gap > 0) begin
                    rvalid_i <= 1'b0;
                    rlast_i  <= 1'b0;
                    gap--;
                end else begin
                    rvalid_i <= 1'b1;
                    rid_i    <= id;
                    rdata_i  <= beat_data(id, beat);
                    rresp_i  <= (beat == err_beat) ? SLVERR : OKAY;
                    rlast_i  <= (beat == len);
                    holding = 1'b1;
                end
            end
            @(negedge clk);
            if (rvalid_i && rready_o) begin
                beat++;
                holding = 1'b0;
                gap = random_timing ? rand_bits(3) : 0;
            end
        end
        @(posedge clk);
        rvalid_i <= 1'b0;
        rlast_i  <= 1'b0;
        rresp_i  <= OKAY;

        seen = 1'b0;
        for (int w = 0; w < 8 && !seen; w++) begin
            @(negedge clk);
            seen = done_o;
        end
        assert (seen) else begin
            $display("%s: done_o did not pulse after the last beat", name);
            errors++;
        end
        if (seen) begin
            check_value(name, "resp", exp_resp, resp_o);
        end
        repeat (3) @(negedge clk);
        check_value(name, "done pulses", 1, done_pulses - pulses_before);
    endtask

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, a test did not finish", cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int errs_at_start;
        int total;

        req_valid_i = 1'b0;
        req_id_i    = '0;
        req_addr_i  = '0;
        req_len_i   = '0;
        req_size_i  = '0;
        req_burst_i = INCR;
        arready_i   = 1'b0;
        rid_i       = '0;
        rdata_i     = '0;
        rresp_i     = OKAY;
        rlast_i     = 1'b0;
        rvalid_i    = 1'b0;
        mem_raddr_i = '0;

        @(posedge rst_n);
        @(negedge clk);
        errs_at_start = errors;
        check_value("reset_state", "req_ready_o", 1, req_ready_o);
        check_value("reset_state", "arvalid_o", 0, arvalid_o);
        check_value("reset_state", "rready_o", 0, rready_o);
        check_value("reset_state", "done_o", 0, done_o);
        end_test("reset_state", errs_at_start);

        errs_at_start = errors;
        drive_burst("fixed_burst", 4'h1, 32'h100, 3, 2, FIXED, -1, 1'b0);
        verify_memory("fixed_burst");
        end_test("fixed_burst", errs_at_start);

        errs_at_start = errors;
        drive_burst("incr_burst", 4'h2, 32'h200, 7, 1, INCR, -1, 1'b0);
        verify_memory("incr_burst");
        end_test("incr_burst", errs_at_start);

        errs_at_start = errors;
        drive_burst("wrap_burst", 4'h3, 32'h308, 3, 2, WRAP, -1, 1'b0);
        verify_memory("wrap_burst");
        end_test("wrap_burst", errs_at_start);

        // Random stalls, one SLVERR beat, then a clean burst
        errs_at_start = errors;
        drive_burst("random_slverr", 4'h4, 32'h400, 15, 1, INCR, 5, 1'b1);
        verify_memory("random_slverr");
        drive_burst("random_slverr", 4'h5, 32'h500, 3, 2, INCR, -1, 1'b1);
        verify_memory("random_slverr");
        end_test("random_slverr", errs_at_start);

        repeat (2) @(negedge clk);
        if (dut_i.u_chk.fail_count != 0) begin
            $display("Protocol assertions failed %0d times", dut_i.u_chk.fail_count);
        end
        total = errors + dut_i.u_chk.fail_count;
        $display("Tests run %0d, failed %0d, check errors %0d, protocol errors %0d",
                 tests_run, tests_failed, errors, dut_i.u_chk.fail_count);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+source
source/axi_pkg.sv
source/mem_pkg.sv
source/burst_addr_gen.sv
source/rd_addr_channel.sv
source/rd_data_channel.sv
source/local_mem.sv
source/axi_rd_master.sv
sim/tb_clk_gen.sv
sim/axi_rd_master_checker.sv
sim/tb_axi_rd_master.sv

//--- Bender.yml
package:
  name: axi_rd_master

export_include_dirs:
  - source

sources:
  - files:
      - source/axi_pkg.sv
      - source/mem_pkg.sv
      - source/burst_addr_gen.sv
      - source/rd_addr_channel.sv
      - source/rd_data_channel.sv
      - source/local_mem.sv
      - source/axi_rd_master.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/axi_rd_master_checker.sv
      - sim/tb_axi_rd_master.sv
